//--- Bender.yml
package:
  name: debug_ddr3_bridge

sources:
  # Bridge RTL, package first
  - rtl/ddr3_bridge_pkg.sv
  - rtl/seq_cmd_issue.sv
  - rtl/read_return.sv
  - rtl/status_report.sv
  - rtl/debug_ddr3_bridge.sv

  # Sequencer model, bound checks and testbench
  - target: test
    files:
      - test/seq_model.sv
      - test/debug_ddr3_bridge_chk.sv
      - test/tb_debug_ddr3_bridge.sv

//--- rtl/ddr3_bridge_pkg.sv
`default_nettype none

package ddr3_bridge_pkg;

	// ***************************************************************************
	// Geometry of the sequencer line and the debug host port
	// ***************************************************************************

	// Bytes in one 128 bit sequencer line
	localparam int LINE_BYTES = 16;

	// Host address bits that pick one byte lane inside a line
	localparam int LANE_SEL_BITS = 4;

	// Byte address width of the debug host
	localparam int HOST_ADDR_BITS = 24;

	// Row 13 plus bank 3 plus column 10 plus one extra mask bit
	localparam int SEQ_ADDR_BITS = 13 + 3 + 10 + 1;

	// Tag carried through the sequencer with each read
	localparam int VECT_BITS = 5;

	// Plain vector types for the widths in use
	typedef logic [7:0] byte_t;
	typedef logic [LINE_BYTES*8-1:0] line_t;
	typedef logic [LINE_BYTES-1:0] mask_t;
	typedef logic [HOST_ADDR_BITS-1:0] host_addr_t;
	typedef logic [SEQ_ADDR_BITS-1:0] seq_addr_t;
	typedef logic [VECT_BITS-1:0] vect_t;

	// Completed read counter
	typedef logic [15:0] count_t;

endpackage

`default_nettype wire

//--- rtl/debug_ddr3_bridge.sv
`default_nettype none

module debug_ddr3_bridge
(
	input wire DDR3_CLK_25,
	input wire RESET,

	// Debug host port
	input wire host_rd_req,
	input wire host_wr_req,
	input wire ddr3_bridge_pkg::host_addr_t host_addr,
	input wire ddr3_bridge_pkg::byte_t host_wdata,
	output logic host_rd_rdy,
	output ddr3_bridge_pkg::byte_t host_rdata,
	output ddr3_bridge_pkg::count_t read_count,

	// Sequencer command port
	output logic seq_cmd_ena_t,
	output logic seq_write_ena,
	output ddr3_bridge_pkg::seq_addr_t seq_addr,
	output ddr3_bridge_pkg::line_t seq_wdata,
	output ddr3_bridge_pkg::mask_t seq_wmask,
	output ddr3_bridge_pkg::vect_t seq_rdata_vect_in,

	// Sequencer results
	input wire seq_busy_t,
	input wire seq_rdata_rdy_t,
	input wire ddr3_bridge_pkg::line_t seq_rdata,
	input wire ddr3_bridge_pkg::vect_t seq_rdata_vect_out,

	// Status inputs
	input wire txd_active,
	input wire rxd_active,
	input wire pll_locked,
	input wire cal_pass,
	input wire ddr3_ready,
	input wire ddr3_bridge_pkg::byte_t rdcal_data,

	// Status outputs
	output ddr3_bridge_pkg::byte_t status_byte,
	output ddr3_bridge_pkg::byte_t cal_byte,
	output ddr3_bridge_pkg::byte_t led
);

	// ***************************************************************************
	// Host strobes to sequencer commands
	// ***************************************************************************
	seq_cmd_issue seq_cmd_issue_i
	(
		.DDR3_CLK_25(DDR3_CLK_25),
		.RESET(RESET),
		.host_rd_req(host_rd_req),
		.host_wr_req(host_wr_req),
		.host_addr(host_addr),
		.host_wdata(host_wdata),
		.seq_busy_t(seq_busy_t),
		.seq_cmd_ena_t(seq_cmd_ena_t),
		.seq_write_ena(seq_write_ena),
		.seq_addr(seq_addr),
		.seq_wdata(seq_wdata),
		.seq_wmask(seq_wmask),
		.seq_rdata_vect_in(seq_rdata_vect_in)
	);

	// Read results back to the host
	read_return read_return_i
	(
		.DDR3_CLK_25(DDR3_CLK_25),
		.RESET(RESET),
		.seq_rdata_rdy_t(seq_rdata_rdy_t),
		.seq_rdata(seq_rdata),
		.seq_rdata_vect_out(seq_rdata_vect_out),
		.host_rd_rdy(host_rd_rdy),
		.host_rdata(host_rdata),
		.read_count(read_count)
	);

	// Status byte, calibration byte and LEDs
	status_report status_report_i
	(
		.DDR3_CLK_25(DDR3_CLK_25),
		.txd_active(txd_active),
		.rxd_active(rxd_active),
		.pll_locked(pll_locked),
		.cal_pass(cal_pass),
		.ddr3_ready(ddr3_ready),
		.rdcal_data(rdcal_data),
		.status_byte(status_byte),
		.cal_byte(cal_byte),
		.led(led)
	);

endmodule

`default_nettype wire

//--- rtl/read_return.sv
`default_nettype none

module read_return
(
	input wire DDR3_CLK_25,
	input wire RESET,
	input wire seq_rdata_rdy_t,
	input wire ddr3_bridge_pkg::line_t seq_rdata,
	input wire ddr3_bridge_pkg::vect_t seq_rdata_vect_out,
	output logic host_rd_rdy,
	output ddr3_bridge_pkg::byte_t host_rdata,
	output ddr3_bridge_pkg::count_t read_count
);

	import ddr3_bridge_pkg::*;

	// Ready toggle after first register
	logic rdy_s1;
	// Ready toggle after second register
	logic rdy_s2;
	// Lane picked by the returned vector
	logic [LANE_SEL_BITS-1:0] rd_lane;

	// ***************************************************************************
	// Byte select from the returned line
	// ***************************************************************************
	always_comb
	begin
		// Same lane order as the write side
		rd_lane = ~seq_rdata_vect_out[LANE_SEL_BITS-1:0];

		// Line and vector are held by the sequencer until the next return
		host_rdata = seq_rdata[{rd_lane, 3'b000} +: 8];
	end

	// ***************************************************************************
	// Ready toggle to host pulse
	// ***************************************************************************
	always_ff @(posedge DDR3_CLK_25)
	begin
		if (RESET)
		begin
			// Track the live toggle so release gives no stray pulse
			rdy_s1 <= seq_rdata_rdy_t;
			rdy_s2 <= rdy_s1;
			host_rd_rdy <= 1'b0;
		end
		else
		begin
			rdy_s1 <= seq_rdata_rdy_t;
			rdy_s2 <= rdy_s1;

			// Stages differ for exactly one cycle per toggle edge
			host_rd_rdy <= rdy_s1 != rdy_s2;
		end
	end

	// ***************************************************************************
	// Completed read counter
	// ***************************************************************************
	always_ff @(posedge DDR3_CLK_25)
	begin
		if (RESET)
			read_count <= '0;
		else if (host_rd_rdy)
			// Wraps at full count
			read_count <= read_count + 1'b1;
	end

endmodule

`default_nettype wire

//--- rtl/seq_cmd_issue.sv
`default_nettype none

module seq_cmd_issue
(
	input wire DDR3_CLK_25,
	input wire RESET,
	input wire host_rd_req,
	input wire host_wr_req,
	input wire ddr3_bridge_pkg::host_addr_t host_addr,
	input wire ddr3_bridge_pkg::byte_t host_wdata,
	input wire seq_busy_t,
	output logic seq_cmd_ena_t,
	output logic seq_write_ena,
	output ddr3_bridge_pkg::seq_addr_t seq_addr,
	output ddr3_bridge_pkg::line_t seq_wdata,
	output ddr3_bridge_pkg::mask_t seq_wmask,
	output ddr3_bridge_pkg::vect_t seq_rdata_vect_in
);

	import ddr3_bridge_pkg::*;

	// Either host strobe starts a command
	logic host_req;
	// Flips once per captured request
	logic req_t;
	// Lane of the addressed byte, counted from the top of the line
	logic [LANE_SEL_BITS-1:0] wr_lane;
	mask_t wr_mask;
	line_t wr_line;
	seq_addr_t line_addr;

	// ***************************************************************************
	// Byte to line encoding
	// ***************************************************************************
	always_comb
	begin
		host_req = host_rd_req | host_wr_req;

		// Byte 0 of a line sits in the top lane
		wr_lane = ~host_addr[LANE_SEL_BITS-1:0];

		// One hot write mask for that lane
		wr_mask = mask_t'(1) << wr_lane;

		// Same byte in every lane, the mask picks the one written
		wr_line = {LINE_BYTES{host_wdata}};

		// Line aligned address, low lane bits forced to zero
		line_addr = seq_addr_t'({host_addr[HOST_ADDR_BITS-1:LANE_SEL_BITS],
			{LANE_SEL_BITS{1'b0}}});
	end

	// ***************************************************************************
	// Request capture and toggle command issue
	// ***************************************************************************
	always_ff @(posedge DDR3_CLK_25)
	begin
		if (RESET)
		begin
			req_t <= 1'b0;
			seq_cmd_ena_t <= 1'b0;
			seq_write_ena <= 1'b0;
			seq_addr <= '0;
			seq_rdata_vect_in <= '0;
		end
		else
		begin
			// Latch the command fields with the strobe
			if (host_req)
			begin
				req_t <= ~req_t;
				seq_write_ena <= host_wr_req;
				seq_addr <= line_addr;
				// Low address bits return with the read data
				seq_rdata_vect_in <= host_addr[VECT_BITS-1:0];
			end

			// Sequencer idle when busy toggle has caught up
			// Pending request waits here for as long as it takes
			if (seq_busy_t == seq_cmd_ena_t)
				seq_cmd_ena_t <= req_t;
		end
	end

	// Write payload follows the strobe
	always_ff @(posedge DDR3_CLK_25)
	begin
		if (host_req)
		begin
			seq_wdata <= wr_line;
			seq_wmask <= wr_mask;
		end
	end

endmodule

`default_nettype wire

//--- rtl/status_report.sv
`default_nettype none

module status_report
(
	input wire DDR3_CLK_25,
	input wire txd_active,
	input wire rxd_active,
	input wire pll_locked,
	input wire cal_pass,
	input wire ddr3_ready,
	input wire ddr3_bridge_pkg::byte_t rdcal_data,
	output ddr3_bridge_pkg::byte_t status_byte,
	output ddr3_bridge_pkg::byte_t cal_byte,
	output ddr3_bridge_pkg::byte_t led
);

	// Serial link busy on either direction
	logic link_active;

	assign link_active = txd_active | rxd_active;

	// ***************************************************************************
	// Registered status, calibration and LED outputs
	// ***************************************************************************
	always_ff @(posedge DDR3_CLK_25)
	begin
		// Bit 7 rx, bit 4 ready, bit 3 cal, bit 2 lock, bit 0 tx
		status_byte <= {rxd_active,
			2'b00,
			ddr3_ready,
			cal_pass,
			pll_locked,
			1'b0,
			txd_active};

		// Raw read calibration result
		cal_byte <= rdcal_data;

		// LEDs are active low
		// Top LED flips back while the serial link is busy
		led <= ~rdcal_data ^ {link_active, 7'b000_0000};
	end

endmodule

`default_nettype wire

//--- src.f
rtl/ddr3_bridge_pkg.sv
rtl/seq_cmd_issue.sv
rtl/read_return.sv
rtl/status_report.sv
rtl/debug_ddr3_bridge.sv
test/seq_model.sv
test/debug_ddr3_bridge_chk.sv
test/tb_debug_ddr3_bridge.sv

//--- test/debug_ddr3_bridge_chk.sv
`default_nettype none

module debug_ddr3_bridge_chk
(
	input wire DDR3_CLK_25,
	input wire RESET,
	input wire seq_cmd_ena_t,
	input wire seq_busy_t,
	input wire seq_write_ena,
	input wire ddr3_bridge_pkg::mask_t seq_wmask,
	input wire host_rd_rdy
);

	timeunit 1ns;
	timeprecision 1ps;

	// ***********************************************************************
	// Handshake and pulse properties
	// ***********************************************************************

	// Command toggle only moves out of the idle state
	idle_issue: assert property (@(posedge DDR3_CLK_25) disable iff (RESET)
		seq_cmd_ena_t != $past(seq_cmd_ena_t) |-> $past(seq_busy_t == seq_cmd_ena_t))
		else $error("seq_cmd_ena_t changed while the sequencer was busy");

	// One cycle per read return
	single_pulse: assert property (@(posedge DDR3_CLK_25) disable iff (RESET)
		host_rd_rdy |=> !host_rd_rdy)
		else $error("host_rd_rdy high for two cycles in a row");

	// A write touches one byte lane
	onehot_mask: assert property (@(posedge DDR3_CLK_25) disable iff (RESET)
		seq_write_ena |-> $onehot(seq_wmask))
		else $error("seq_wmask not one hot during a write");

endmodule

bind debug_ddr3_bridge debug_ddr3_bridge_chk debug_ddr3_bridge_chk_i (.*);

`default_nettype wire

//--- test/seq_model.sv
`default_nettype none

module seq_model
(
	input wire DDR3_CLK_25,
	input wire RESET,
	// Cycles to spend on the next command, 1 or more
	input wire [4:0] latency,
	input wire seq_cmd_ena_t,
	input wire seq_write_ena,
	input wire ddr3_bridge_pkg::seq_addr_t seq_addr,
	input wire ddr3_bridge_pkg::line_t seq_wdata,
	input wire ddr3_bridge_pkg::mask_t seq_wmask,
	input wire ddr3_bridge_pkg::vect_t seq_rdata_vect_in,
	output logic seq_busy_t,
	output logic seq_rdata_rdy_t,
	output ddr3_bridge_pkg::line_t seq_rdata,
	output ddr3_bridge_pkg::vect_t seq_rdata_vect_out
);

	timeunit 1ns;
	timeprecision 1ps;

	import ddr3_bridge_pkg::*;

	// Sparse line store, lines never written read as zero
	line_t mem [seq_addr_t];
	// Command accepted and counting down
	logic active;
	int unsigned wait_left;
	// Command fields taken when the command is accepted
	logic cmd_write;
	seq_addr_t cmd_addr;
	line_t cmd_wdata;
	mask_t cmd_wmask;
	vect_t cmd_vect;

	// ***********************************************************************
	// Command service with toggle handshake
	// ***********************************************************************
	always @(posedge DDR3_CLK_25)
	begin : serve
		line_t line;
		if (RESET)
		begin
			seq_busy_t <= 1'b0;
			seq_rdata_rdy_t <= 1'b0;
			seq_rdata <= '0;
			seq_rdata_vect_out <= '0;
			active <= 1'b0;
			wait_left <= 0;
		end
		else if (!active)
		begin
			// New command when the enable toggle runs ahead of busy
			if (seq_cmd_ena_t != seq_busy_t)
			begin
				active <= 1'b1;
				wait_left <= latency;
				// Host port is free to take the next strobe from here on
				cmd_write <= seq_write_ena;
				cmd_addr <= seq_addr;
				cmd_wdata <= seq_wdata;
				cmd_wmask <= seq_wmask;
				cmd_vect <= seq_rdata_vect_in;
			end
		end
		else if (wait_left > 1)
			wait_left <= wait_left - 1;
		else
		begin
			line = mem.exists(cmd_addr) ? mem[cmd_addr] : '0;
			if (cmd_write)
			begin
				// Only lanes with a mask bit take the new byte
				for (int i = 0; i < LINE_BYTES; i++)
					if (cmd_wmask[i])
						line[i*8 +: 8] = cmd_wdata[i*8 +: 8];
				mem[cmd_addr] = line;
			end
			else
			begin
				// Data and tag settle together with the ready flip
				seq_rdata <= line;
				seq_rdata_vect_out <= cmd_vect;
				seq_rdata_rdy_t <= ~seq_rdata_rdy_t;
			end
			seq_busy_t <= seq_cmd_ena_t;
			active <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- test/tb_debug_ddr3_bridge.sv
`default_nettype none

module tb_debug_ddr3_bridge;

	timeunit 1ns;
	timeprecision 1ps;

	import ddr3_bridge_pkg::*;

	// Test lengths, the watchdog limit follows from them
	localparam int RESET_CYCLES = 16;
	localparam int MIX_COUNT = 100;
	localparam int READ_COUNT = 260;
	localparam int STRETCH_COUNT = 24;
	localparam int STATUS_COUNT = 32;
	// Worst case for one access with stretched latency
	localparam int TRANS_MAX = 40;
	localparam int CYCLE_LIMIT = RESET_CYCLES + STATUS_COUNT * 3 + 100
		+ (MIX_COUNT + READ_COUNT + STRETCH_COUNT) * TRANS_MAX;

	logic DDR3_CLK_25;
	logic RESET;
	logic host_rd_req;
	logic host_wr_req;
	host_addr_t host_addr;
	byte_t host_wdata;
	logic host_rd_rdy;
	byte_t host_rdata;
	count_t read_count;
	logic seq_cmd_ena_t;
	logic seq_write_ena;
	seq_addr_t seq_addr;
	line_t seq_wdata;
	mask_t seq_wmask;
	vect_t seq_rdata_vect_in;
	logic seq_busy_t;
	logic seq_rdata_rdy_t;
	line_t seq_rdata;
	vect_t seq_rdata_vect_out;
	logic txd_active;
	logic rxd_active;
	logic pll_locked;
	logic cal_pass;
	logic ddr3_ready;
	byte_t rdcal_data;
	byte_t status_byte;
	byte_t cal_byte;
	byte_t led;
	logic [4:0] latency;

	logic [15:0] lfsr = 16'd29;
	int errors = 0;
	int cycles = 0;
	int strobes = 0;
	int cmds = 0;
	int pulses = 0;
	// Expected bytes of reads in flight
	byte_t rd_expect [$];
	// Byte addressed shadow of everything written
	byte_t shadow [host_addr_t];
	// Fields of the last strobe, checked when its command issues
	logic exp_write;
	host_addr_t exp_addr;
	byte_t exp_data;
	logic ena_prev;
	logic busy_prev;
	logic rdy_prev = 1'b0;

	debug_ddr3_bridge debug_ddr3_bridge_i (.*);
	seq_model seq_model_i (.*);

	initial
	begin
		DDR3_CLK_25 = 1'b0;
		forever #10 DDR3_CLK_25 = ~DDR3_CLK_25;
	end

	// ***********************************************************************
	// Random source, reference models and compare
	// ***********************************************************************

	// Fibonacci LFSR x^16+x^14+x^13+x^11+1, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic fb;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	// Byte the memory should hold, zero where never written
	function automatic byte_t expected_byte(input host_addr_t addr);
		return shadow.exists(addr) ? shadow[addr] : 8'h00;
	endfunction

	// Status, calibration and LED bytes for one set of inputs
	// Bits of r are tx, rx, pll, cal, ready, then the calibration byte
	function automatic logic [23:0] status_ref(input logic [12:0] r);
		byte_t st;
		byte_t lamp;
		st = {r[1], 2'b00, r[4], r[3], r[2], 1'b0, r[0]};
		lamp = ~r[12:5];
		if (r[0] || r[1])
			lamp[7] = ~lamp[7];
		return {st, r[12:5], lamp};
	endfunction

	task automatic compare(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		if (got !== exp)
		begin
			$display("[FAIL] %0t %s got %0h expected %0h", $time, name, got, exp);
			errors++;
		end
	endtask

	// ***********************************************************************
	// Host access, one strobe then wait for the sequencer to finish
	// ***********************************************************************
	task automatic host_access(input logic write, input host_addr_t addr,
		input byte_t data, input logic stretch);
		logic ena_before;
		ena_before = seq_cmd_ena_t;
		exp_write = write;
		exp_addr = addr;
		exp_data = data;
		if (write)
			shadow[addr] = data;
		else
			rd_expect.push_back(expected_byte(addr));
		latency <= stretch ? 5'(9 + rand_bits(4)) : 5'(1 + rand_bits(3));
		host_wr_req <= write;
		host_rd_req <= !write;
		host_addr <= addr;
		host_wdata <= data;
		strobes++;
		@(posedge DDR3_CLK_25);
		host_wr_req <= 1'b0;
		host_rd_req <= 1'b0;
		while (seq_cmd_ena_t == ena_before)
			@(posedge DDR3_CLK_25);
		if (write && stretch)
		begin
			// Slow write stays in flight so the next strobe meets a busy sequencer
			@(posedge DDR3_CLK_25);
		end
		else
		begin
			while (seq_busy_t != seq_cmd_ena_t)
				@(posedge DDR3_CLK_25);
		end
		if (!write)
		begin
			while (!host_rd_rdy)
				@(posedge DDR3_CLK_25);
			// Let the compare process take the byte first
			@(posedge DDR3_CLK_25);
		end
	endtask

	// A few lines spread over high and low address bits
	function automatic host_addr_t pick_addr();
		host_addr_t a;
		a = '0;
		a[21:20] = rand_bits(2);
		a[5:4] = rand_bits(2);
		a[3:0] = rand_bits(4);
		return a;
	endfunction

	task automatic status_step();
		logic [12:0] r;
		logic [23:0] exp;
		r = rand_bits(13);
		txd_active <= r[0];
		rxd_active <= r[1];
		pll_locked <= r[2];
		cal_pass <= r[3];
		ddr3_ready <= r[4];
		rdcal_data <= r[12:5];
		exp = status_ref(r);
		// Inputs land on the next edge, outputs show one edge later
		@(posedge DDR3_CLK_25);
		@(posedge DDR3_CLK_25);
		compare("status_byte", status_byte, exp[23:16]);
		compare("cal_byte", cal_byte, exp[15:8]);
		compare("led", led, exp[7:0]);
	endtask

	// ***********************************************************************
	// Stimulus and final report
	// ***********************************************************************
	initial
	begin
		logic wr;
		host_addr_t a;
		byte_t d;
		RESET = 1'b1;
		host_rd_req = 1'b0;
		host_wr_req = 1'b0;
		host_addr = '0;
		host_wdata = '0;
		txd_active = 1'b0;
		rxd_active = 1'b0;
		pll_locked = 1'b0;
		cal_pass = 1'b0;
		ddr3_ready = 1'b0;
		rdcal_data = '0;
		latency = 5'd1;
		repeat (RESET_CYCLES) @(posedge DDR3_CLK_25);
		RESET <= 1'b0;
		@(posedge DDR3_CLK_25);
		// Idle outputs straight out of reset
		compare("seq_cmd_ena_t", seq_cmd_ena_t, 0);
		compare("seq_write_ena", seq_write_ena, 0);
		compare("host_rd_rdy", host_rd_rdy, 0);
		compare("read_count", read_count, 0);
		repeat (8) @(posedge DDR3_CLK_25);

		// Mixed writes and reads, then a long read run past 255
		for (int i = 0; i < MIX_COUNT + READ_COUNT; i++)
		begin
			wr = (i < MIX_COUNT) ? rand_bits(1) : 1'b0;
			a = pick_addr();
			d = rand_bits(8);
			host_access(wr, a, d, 1'b0);
		end

		// Slow sequencer, the strobe after each write waits on busy
		for (int i = 0; i < STRETCH_COUNT; i++)
		begin
			wr = rand_bits(1);
			a = pick_addr();
			d = rand_bits(8);
			host_access(wr, a, d, 1'b1);
		end

		for (int i = 0; i < STATUS_COUNT; i++)
			status_step();

		repeat (8) @(posedge DDR3_CLK_25);
		if (cmds != strobes)
		begin
			$display("Issued %0d commands for %0d strobes", cmds, strobes);
			errors++;
		end
		if (rd_expect.size() != 0)
		begin
			$display("%0d reads never returned", rd_expect.size());
			errors++;
		end
		$display("Summary: %0d errors, %0d strobes, %0d commands, %0d reads",
			errors, strobes, cmds, pulses);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

	// ***********************************************************************
	// Monitors
	// ***********************************************************************

	// Command fields and the idle rule at each issue
	always @(posedge DDR3_CLK_25)
	begin
		if (!RESET && seq_cmd_ena_t != ena_prev)
		begin
			cmds++;
			if (busy_prev != ena_prev)
			begin
				$display("seq_cmd_ena_t changed at %0t while the sequencer was busy", $time);
				errors++;
			end
			compare("seq_write_ena", seq_write_ena, exp_write);
			compare("seq_addr", seq_addr, seq_addr_t'({exp_addr[23:4], 4'h0}));
			compare("seq_rdata_vect_in", seq_rdata_vect_in, exp_addr[4:0]);
			if (exp_write)
			begin
				compare("seq_wmask", seq_wmask, mask_t'(1) << (15 - exp_addr[3:0]));
				compare("seq_wdata", seq_wdata, {LINE_BYTES{exp_data}});
			end
		end
		ena_prev = seq_cmd_ena_t;
		busy_prev = seq_busy_t;
	end

	// Read data, pulse shape and read counter
	always @(posedge DDR3_CLK_25)
	begin
		if (!RESET)
		begin
			compare("read_count", read_count, count_t'(pulses));
			if (host_rd_rdy && rdy_prev)
			begin
				$display("host_rd_rdy stayed high for two cycles at %0t", $time);
				errors++;
			end
			if (host_rd_rdy)
			begin
				pulses++;
				if (rd_expect.size() == 0)
				begin
					$display("host_rd_rdy pulsed at %0t with no read pending", $time);
					errors++;
				end
				else
					compare("host_rdata", host_rdata, rd_expect.pop_front());
			end
			rdy_prev = host_rd_rdy;
		end
	end

	// Watchdog
	always @(posedge DDR3_CLK_25)
	begin
		cycles++;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("Timeout after %0d cycles, %0d errors so far", cycles, errors);
			$display("Testbench failed");
			$finish;
		end
	end

endmodule

`default_nettype wire
